// File: hw/arm_core_top.sv
module arm_core_top
    import arm_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        instr_valid,
    input  instr_u      instr,
    input  logic [31:0] pc,
    input  logic        hold,
    output logic        instr_ready,
    output ex_res_t     result,
    output flags_t      flags,
    output logic        branch_taken,
    output logic [31:0] branch_target
);

    id_ex_t      decoded;
    id_ex_t      ex_entry;
    ex_res_t     ex_res;
    logic        hazard;
    logic        flush;
    logic        freeze;
    logic [3:0]  rd_addr1;
    logic [3:0]  rd_addr2;
    logic [31:0] rd_data1;
    logic [31:0] rd_data2;
    logic        wr_en;
    logic [3:0]  wr_addr;
    logic [31:0] wr_data;

    assign instr_ready = !rst && instr_valid && !hold && !hazard;
    assign freeze      = hold;
    assign flush       = branch_taken || (!instr_ready && !hold);  // squash or bubble.

    instr_decode u_decode (
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .ex_entry    (ex_entry),
        .rd_addr1    (rd_addr1),
        .rd_addr2    (rd_addr2),
        .rd_data1    (rd_data1),
        .rd_data2    (rd_data2),
        .decoded     (decoded),
        .hazard      (hazard)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    id_ex_reg u_id_ex (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .freeze   (freeze),
        .entry_in (decoded),
        .entry    (ex_entry)
    );

    execute_stage u_execute (
        .clk           (clk),
        .rst           (rst),
        .freeze        (freeze),
        .entry         (ex_entry),
        .res           (ex_res),
        .flags         (flags),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    result_stage u_result (
        .clk     (clk),
        .rst     (rst),
        .freeze  (freeze),
        .res_in  (ex_res),
        .result  (result),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

endmodule

// File: hw/arm_pkg.sv
package arm_pkg;

    typedef enum logic [3:0] {
        EXE_NOP = 4'b0000,
        EXE_MOV = 4'b0001,
        EXE_ADD = 4'b0010,
        EXE_ADC = 4'b0011,
        EXE_SUB = 4'b0100,
        EXE_SBC = 4'b0101,
        EXE_AND = 4'b0110,
        EXE_ORR = 4'b0111,
        EXE_EOR = 4'b1000,
        EXE_MVN = 4'b1001
    } exe_cmd_t;

    typedef enum logic [3:0] {
        COND_EQ = 4'b0000,
        COND_NE = 4'b0001,
        COND_CS = 4'b0010,
        COND_CC = 4'b0011,
        COND_MI = 4'b0100,
        COND_PL = 4'b0101,
        COND_VS = 4'b0110,
        COND_VC = 4'b0111,
        COND_HI = 4'b1000,
        COND_LS = 4'b1001,
        COND_GE = 4'b1010,
        COND_LT = 4'b1011,
        COND_GT = 4'b1100,
        COND_LE = 4'b1101,
        COND_AL = 4'b1110
    } cond_t;

    typedef struct packed {
        cond_t       cond;
        logic [1:0]  fmt;            // 2'b00 for data processing.
        logic        imm;
        logic [3:0]  opcode;
        logic        s;
        logic [3:0]  rn;
        logic [3:0]  rd;
        logic [11:0] shift_operand;
    } dp_instr_t;

    typedef struct packed {
        cond_t       cond;
        logic [2:0]  fmt;            // 3'b101 for branch.
        logic        link;
        logic [23:0] signed_imm_24;
    } br_instr_t;

    typedef union packed {
        dp_instr_t dp;
        br_instr_t br;
    } instr_u;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        logic        imm;
        logic        wb_en;
        logic        b;
        logic        s;
        exe_cmd_t    exe_cmd;
        cond_t       cond;
        logic [3:0]  dest;
        logic [3:0]  src1;
        logic [3:0]  src2;
        logic [11:0] shift_operand;
        logic [23:0] signed_imm_24;
        logic [31:0] pc;
        logic [31:0] val_rn;
        logic [31:0] val_rm;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic        wb_en;
        logic [3:0]  dest;
        logic [31:0] value;
    } ex_res_t;

endpackage

// File: hw/execute_stage.sv
module execute_stage
    import arm_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        freeze,
    input  id_ex_t      entry,
    output ex_res_t     res,
    output flags_t      flags,
    output logic        branch_taken,
    output logic [31:0] branch_target
);

    flags_t      status;
    flags_t      alu_flags;
    logic        cond_pass;
    logic        arith;
    logic        cin;
    logic        ovf;
    logic [4:0]  shamt;
    logic [31:0] op2;
    logic [31:0] b_op;
    logic [31:0] alu_out;
    logic [32:0] sum;

    function automatic logic [31:0] ror32(input logic [31:0] x, input logic [4:0] amt);
        logic [63:0] dbl;
        dbl = {x, x} >> amt;
        return dbl[31:0];
    endfunction

    function automatic logic check_cond(input cond_t cond, input flags_t f);
        case (cond)
            COND_EQ: return f.z;
            COND_NE: return !f.z;
            COND_CS: return f.c;
            COND_CC: return !f.c;
            COND_MI: return f.n;
            COND_PL: return !f.n;
            COND_VS: return f.v;
            COND_VC: return !f.v;
            COND_HI: return f.c && !f.z;
            COND_LS: return !f.c || f.z;
            COND_GE: return f.n == f.v;
            COND_LT: return f.n != f.v;
            COND_GT: return !f.z && (f.n == f.v);
            COND_LE: return f.z || (f.n != f.v);
            COND_AL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    assign cond_pass = check_cond(entry.cond, status);
    assign shamt     = entry.shift_operand[11:7];

    always_comb begin
        if (entry.imm) begin
            op2 = ror32({24'b0, entry.shift_operand[7:0]}, {entry.shift_operand[11:8], 1'b0});
        end else begin
            case (entry.shift_operand[6:5])
                2'b00:   op2 = entry.val_rm << shamt;
                2'b01:   op2 = entry.val_rm >> shamt;
                2'b10:   op2 = $signed(entry.val_rm) >>> shamt;
                default: op2 = ror32(entry.val_rm, shamt);
            endcase
        end
    end

    // one adder; subtraction adds the inverted operand.
    always_comb begin
        b_op  = op2;
        cin   = 1'b0;
        arith = 1'b1;
        case (entry.exe_cmd)
            EXE_ADC: cin = status.c;
            EXE_SUB: begin
                b_op = ~op2;
                cin  = 1'b1;
            end
            EXE_SBC: begin
                b_op = ~op2;
                cin  = status.c;
            end
            EXE_ADD: cin = 1'b0;
            default: arith = 1'b0;
        endcase
        sum = {1'b0, entry.val_rn} + {1'b0, b_op} + {32'b0, cin};
        ovf = (entry.val_rn[31] == b_op[31]) && (sum[31] != entry.val_rn[31]);
    end

    always_comb begin
        case (entry.exe_cmd)
            EXE_MOV: alu_out = op2;
            EXE_MVN: alu_out = ~op2;
            EXE_AND: alu_out = entry.val_rn & op2;
            EXE_ORR: alu_out = entry.val_rn | op2;
            EXE_EOR: alu_out = entry.val_rn ^ op2;
            EXE_NOP: alu_out = 32'b0;
            default: alu_out = sum[31:0];
        endcase
        alu_flags.n = alu_out[31];
        alu_flags.z = (alu_out == 32'b0);
        alu_flags.c = arith ? sum[32] : status.c;   // logic ops keep c and v.
        alu_flags.v = arith ? ovf : status.v;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            status <= '0;
        end else if (!freeze && entry.s && cond_pass) begin
            status <= alu_flags;
        end
    end

    assign flags = status;

    assign res.valid = cond_pass && (entry.exe_cmd != EXE_NOP);
    assign res.wb_en = entry.wb_en;
    assign res.dest  = entry.dest;
    assign res.value = alu_out;

    assign branch_taken  = entry.b && cond_pass;
    assign branch_target = entry.pc + 32'd8
                           + {{6{entry.signed_imm_24[23]}}, entry.signed_imm_24, 2'b00};

endmodule

// File: hw/id_ex_reg.sv
module id_ex_reg
    import arm_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   flush,
    input  logic   freeze,
    input  id_ex_t entry_in,
    output id_ex_t entry
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entry <= '0;
        end else if (flush) begin
            entry <= '0;             // bubble.
        end else if (!freeze) begin
            entry <= entry_in;
        end
    end

endmodule

// File: hw/instr_decode.sv
module instr_decode
    import arm_pkg::*;
(
    input  logic        instr_valid,
    input  instr_u      instr,
    input  logic [31:0] pc,
    input  id_ex_t      ex_entry,
    output logic [3:0]  rd_addr1,
    output logic [3:0]  rd_addr2,
    input  logic [31:0] rd_data1,
    input  logic [31:0] rd_data2,
    output id_ex_t      decoded,
    output logic        hazard
);

    logic     is_dp;
    logic     is_br;
    logic     is_test;
    logic     uses_rn;
    logic     uses_rm;
    logic     rn_hit;
    logic     rm_hit;
    logic [3:0] rm;
    exe_cmd_t op_cmd;

    assign is_dp = instr_valid && (instr.dp.fmt == 2'b00);
    assign is_br = instr_valid && (instr.br.fmt == 3'b101) && !instr.br.link;

    assign rm = instr.dp.shift_operand[3:0];

    // ARM opcode to ALU command.
    always_comb begin
        is_test = 1'b0;
        case (instr.dp.opcode)
            4'b1101: op_cmd = EXE_MOV;
            4'b1111: op_cmd = EXE_MVN;
            4'b0100: op_cmd = EXE_ADD;
            4'b0101: op_cmd = EXE_ADC;
            4'b0010: op_cmd = EXE_SUB;
            4'b0110: op_cmd = EXE_SBC;
            4'b0000: op_cmd = EXE_AND;
            4'b1100: op_cmd = EXE_ORR;
            4'b0001: op_cmd = EXE_EOR;
            4'b1010: begin
                op_cmd  = EXE_SUB;       // cmp.
                is_test = 1'b1;
            end
            4'b1000: begin
                op_cmd  = EXE_AND;       // tst.
                is_test = 1'b1;
            end
            default: op_cmd = EXE_NOP;
        endcase
    end

    assign uses_rn = is_dp && (op_cmd != EXE_NOP) && (op_cmd != EXE_MOV)
                     && (op_cmd != EXE_MVN);
    assign uses_rm = is_dp && (op_cmd != EXE_NOP) && !instr.dp.imm;

    assign rd_addr1 = instr.dp.rn;
    assign rd_addr2 = rm;

    always_comb begin
        decoded = '0;
        if (is_dp && (op_cmd != EXE_NOP)) begin
            decoded.imm           = instr.dp.imm;
            decoded.wb_en         = !is_test;
            decoded.s             = instr.dp.s | is_test;
            decoded.exe_cmd       = op_cmd;
            decoded.cond          = instr.dp.cond;
            decoded.dest          = instr.dp.rd;
            decoded.src1          = instr.dp.rn;
            decoded.src2          = rm;
            decoded.shift_operand = instr.dp.shift_operand;
            decoded.pc            = pc;
            decoded.val_rn        = rd_data1;
            decoded.val_rm        = rd_data2;
        end else if (is_br) begin
            decoded.b             = 1'b1;
            decoded.cond          = instr.br.cond;
            decoded.signed_imm_24 = instr.br.signed_imm_24;
            decoded.pc            = pc;
        end
    end

    // the entry in execute writes back one edge too late for a plain read.
    assign rn_hit = uses_rn && (instr.dp.rn == ex_entry.dest);
    assign rm_hit = uses_rm && (rm == ex_entry.dest);
    assign hazard = ex_entry.wb_en && (rn_hit || rm_hit);

endmodule

// File: hw/reg_file.sv
module reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  rd_addr1,
    input  logic [3:0]  rd_addr2,
    output logic [31:0] rd_data1,
    output logic [31:0] rd_data2,
    input  logic        wr_en,
    input  logic [3:0]  wr_addr,
    input  logic [31:0] wr_data
);

    logic [31:0] regs [16];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= 32'b0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-first read, so the pending write is seen in the same cycle.
    always_comb begin
        if (wr_en && (wr_addr == rd_addr1)) begin
            rd_data1 = wr_data;
        end else begin
            rd_data1 = regs[rd_addr1];
        end
        if (wr_en && (wr_addr == rd_addr2)) begin
            rd_data2 = wr_data;
        end else begin
            rd_data2 = regs[rd_addr2];
        end
    end

endmodule

// File: hw/result_stage.sv
module result_stage
    import arm_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        freeze,
    input  ex_res_t     res_in,
    output ex_res_t     result,
    output logic        wr_en,
    output logic [3:0]  wr_addr,
    output logic [31:0] wr_data
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
        end else if (freeze) begin
            result.valid <= 1'b0;    // payload held, event shown once.
        end else begin
            result <= res_in;
        end
    end

    assign wr_en   = result.valid && result.wb_en;
    assign wr_addr = result.dest;
    assign wr_data = result.value;

endmodule

// File: list.f
hw/arm_pkg.sv
hw/reg_file.sv
hw/instr_decode.sv
hw/id_ex_reg.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/arm_core_top.sv
testbench/tb_clock.sv
testbench/core_checker.sv
testbench/core_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f list.f --top-module core_tb -o core_sim
out=$(./obj_dir/core_sim)
echo "$out"
if echo "$out" | grep -q "TESTS PASSED"; then
    exit 0
else
    exit 1
fi

// File: testbench/core_checker.sv
module core_checker
    import arm_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        instr_ready,
    input  ex_res_t     result,
    input  flags_t      flags,
    input  logic        branch_taken,
    input  logic [31:0] branch_target,
    input  logic        drain_done,
    output int          value_errors,
    output int          count_errors
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] exp_dest[$];
    logic [31:0] exp_value[$];
    logic [31:0] exp_wb[$];
    logic [31:0] exp_flags[$];
    logic [31:0] exp_target[$];
    int          ev_idx = 0;
    int          br_idx = 0;
    int          val_errs = 0;
    int          cnt_errs = 0;
    logic        end_checked = 1'b0;

    assign value_errors = val_errs;
    assign count_errors = cnt_errs;

    task automatic add_event(input logic [3:0] dest, input logic [31:0] value,
                             input logic wb, input logic [3:0] nzcv);
        exp_dest.push_back(32'(dest));
        exp_value.push_back(value);
        exp_wb.push_back(32'(wb));
        exp_flags.push_back(32'(nzcv));
    endtask

    task automatic compare_field(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
            val_errs++;
        end
    endtask

    // hand-worked results, flags as nzcv after each event.
    initial begin
        add_event(4'd1, 32'h0000_00ff, 1'b1, 4'b0000);
        add_event(4'd2, 32'h3f00_0000, 1'b1, 4'b0000);
        add_event(4'd3, 32'h0000_10ef, 1'b1, 4'b0000);
        add_event(4'd4, 32'h0000_10e0, 1'b1, 4'b0000);
        add_event(4'd5, 32'h0000_00e0, 1'b1, 4'b0000);
        add_event(4'd6, 32'hff00_0000, 1'b1, 4'b0000);
        add_event(4'd7, 32'hfcf0_0000, 1'b1, 4'b0000);
        add_event(4'd8, 32'hffff_ffff, 1'b1, 4'b0000);
        add_event(4'd9, 32'h0000_0000, 1'b1, 4'b0110);
        add_event(4'd10, 32'h0000_0100, 1'b1, 4'b0110);
        add_event(4'd11, 32'h8000_0000, 1'b1, 4'b0110);
        add_event(4'd12, 32'h7fff_ffff, 1'b1, 4'b0011);
        add_event(4'd13, 32'h0000_00f0, 1'b1, 4'b0011);
        add_event(4'd14, 32'h0000_0000, 1'b0, 4'b0110);   // cmp.
        add_event(4'd14, 32'h3f00_0000, 1'b0, 4'b0010);   // tst.
        add_event(4'd0, 32'h0000_0001, 1'b1, 4'b0010);
        add_event(4'd12, 32'h0000_0002, 1'b1, 4'b0010);
        add_event(4'd12, 32'h0000_0003, 1'b1, 4'b0010);
        add_event(4'd12, 32'h0000_0006, 1'b1, 4'b0010);
        add_event(4'd12, 32'h0000_0008, 1'b1, 4'b0010);
        add_event(4'd12, 32'h0000_0009, 1'b1, 4'b0010);
        add_event(4'd14, 32'hffff_ffff, 1'b0, 4'b1000);
        add_event(4'd12, 32'h0000_000a, 1'b1, 4'b1000);
        add_event(4'd12, 32'h0000_000c, 1'b1, 4'b1000);
        add_event(4'd12, 32'h0000_000e, 1'b1, 4'b1000);
        add_event(4'd14, 32'h0000_0000, 1'b0, 4'b0110);
        add_event(4'd2, 32'h0000_0012, 1'b1, 4'b0110);
        add_event(4'd3, 32'h0000_0013, 1'b1, 4'b0110);
        exp_target.push_back(32'h0000_0118);
    end

    always @(posedge clk) begin
        if (rst) begin
            if (result.valid || branch_taken || instr_ready || (flags != 4'b0000)) begin
                $display("[FAIL] %0t: outputs not at their reset values", $time);
                val_errs++;
            end
        end else begin
            if (result.valid) begin
                if (ev_idx >= exp_dest.size()) begin
                    $display("result event at %0t beyond the end of the table", $time);
                    cnt_errs++;
                end else begin
                    compare_field("dest", 32'(result.dest), exp_dest[ev_idx]);
                    compare_field("value", result.value, exp_value[ev_idx]);
                    compare_field("wb_en", 32'(result.wb_en), exp_wb[ev_idx]);
                    compare_field("flags", 32'(flags), exp_flags[ev_idx]);
                end
                ev_idx++;
            end
            if (branch_taken) begin
                if (br_idx >= exp_target.size()) begin
                    $display("taken branch at %0t beyond the end of the table", $time);
                    cnt_errs++;
                end else begin
                    compare_field("branch_target", branch_target, exp_target[br_idx]);
                end
                br_idx++;
            end
            if (drain_done && !end_checked) begin
                end_checked <= 1'b1;
                if (ev_idx < exp_dest.size()) begin
                    $display("%0d result events never arrived", exp_dest.size() - ev_idx);
                    cnt_errs++;
                end
                if (br_idx < exp_target.size()) begin
                    $display("%0d taken branches never arrived", exp_target.size() - br_idx);
                    cnt_errs++;
                end
            end
        end
    end

endmodule

// File: testbench/core_tb.sv
module core_tb
    import arm_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [3:0] OP_AND = 4'b0000;
    localparam logic [3:0] OP_EOR = 4'b0001;
    localparam logic [3:0] OP_SUB = 4'b0010;
    localparam logic [3:0] OP_ADD = 4'b0100;
    localparam logic [3:0] OP_ADC = 4'b0101;
    localparam logic [3:0] OP_SBC = 4'b0110;
    localparam logic [3:0] OP_TST = 4'b1000;
    localparam logic [3:0] OP_CMP = 4'b1010;
    localparam logic [3:0] OP_ORR = 4'b1100;
    localparam logic [3:0] OP_MOV = 4'b1101;
    localparam logic [3:0] OP_MVN = 4'b1111;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    instr_u      instr;
    logic [31:0] pc;
    logic        hold;
    logic        instr_ready;
    ex_res_t     result;
    flags_t      flags;
    logic        branch_taken;
    logic [31:0] branch_target;
    logic        drain_done;
    int          value_errors;
    int          count_errors;

    logic [31:0] row_word[$];
    logic [31:0] row_pc[$];
    logic        row_hold[$];
    logic [31:0] pc_next = 32'h0;

    tb_clock u_clock (.clk(clk), .rst(rst));

    arm_core_top dut (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .pc            (pc),
        .hold          (hold),
        .instr_ready   (instr_ready),
        .result        (result),
        .flags         (flags),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    core_checker u_checker (
        .clk           (clk),
        .rst           (rst),
        .instr_ready   (instr_ready),
        .result        (result),
        .flags         (flags),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .drain_done    (drain_done),
        .value_errors  (value_errors),
        .count_errors  (count_errors)
    );

    function automatic logic [31:0] encode_dp(input logic [3:0] cond, input logic i,
                                              input logic [3:0] op, input logic s,
                                              input logic [3:0] rn, input logic [3:0] rd,
                                              input logic [11:0] so);
        return {cond, 2'b00, i, op, s, rn, rd, so};
    endfunction

    task automatic add_row(input logic [31:0] word, input logic [31:0] at_pc, input logic h);
        row_word.push_back(word);
        row_pc.push_back(at_pc);
        row_hold.push_back(h);
    endtask

    task automatic add_word(input logic [31:0] word);
        add_row(word, pc_next, 1'b0);
        pc_next = pc_next + 32'd4;
    endtask

    task automatic load_program();
        add_word(encode_dp(COND_AL, 1, OP_MOV, 0, 0, 1, 12'h0ff));
        add_word(encode_dp(COND_AL, 1, OP_MOV, 0, 0, 2, 12'h43f));   // 0x3f ror 8.
        add_word(encode_dp(COND_AL, 0, OP_ADD, 0, 1, 3, 12'h201));   // r1 lsl 4.
        add_word(encode_dp(COND_AL, 0, OP_SUB, 0, 3, 4, 12'h221));   // depends on r3.
        add_word(encode_dp(COND_AL, 1, OP_AND, 0, 3, 5, 12'h0f0));
        add_word(encode_dp(COND_AL, 0, OP_ORR, 0, 2, 6, 12'h461));   // r1 ror 8.
        add_word(encode_dp(COND_AL, 0, OP_EOR, 0, 6, 7, 12'h242));   // r2 asr 4.
        add_word(encode_dp(COND_AL, 1, OP_MVN, 0, 0, 8, 12'h000));
        add_word(encode_dp(COND_AL, 1, OP_ADD, 1, 8, 9, 12'h001));
        add_word(encode_dp(COND_AL, 1, OP_ADC, 0, 1, 10, 12'h000));
        add_word(encode_dp(COND_AL, 1, OP_MOV, 0, 0, 11, 12'h102));
        add_word(encode_dp(COND_AL, 1, OP_SUB, 1, 11, 12, 12'h001));
        add_word(encode_dp(COND_AL, 1, OP_SBC, 0, 1, 13, 12'h00f));
        add_word(encode_dp(COND_AL, 1, OP_CMP, 1, 1, 14, 12'h0ff));
        add_word(encode_dp(COND_AL, 1, OP_TST, 1, 2, 14, 12'h43f));
        add_word(encode_dp(COND_AL, 1, OP_ORR, 0, 14, 0, 12'h001));  // r14 never written.
        add_word(encode_dp(COND_EQ, 1, OP_MOV, 0, 0, 1, 12'h001));
        add_word(encode_dp(COND_NE, 1, OP_MOV, 0, 0, 12, 12'h002));
        add_word(encode_dp(COND_CS, 1, OP_MOV, 0, 0, 12, 12'h003));
        add_word(encode_dp(COND_CC, 1, OP_MOV, 0, 0, 12, 12'h004));
        add_word(encode_dp(COND_MI, 1, OP_MOV, 0, 0, 12, 12'h005));
        add_word(encode_dp(COND_PL, 1, OP_MOV, 0, 0, 12, 12'h006));
        add_word(encode_dp(COND_VS, 1, OP_MOV, 0, 0, 12, 12'h007));
        add_word(encode_dp(COND_VC, 1, OP_MOV, 0, 0, 12, 12'h008));
        add_word(encode_dp(COND_HI, 1, OP_MOV, 0, 0, 12, 12'h009));
        add_word(encode_dp(COND_AL, 0, OP_CMP, 1, 1, 14, 12'h00a));  // 0xff - r10.
        add_word(encode_dp(COND_LS, 1, OP_MOV, 0, 0, 12, 12'h00a));
        add_word(encode_dp(COND_GE, 1, OP_MOV, 0, 0, 12, 12'h00b));
        add_word(encode_dp(COND_LT, 1, OP_MOV, 0, 0, 12, 12'h00c));
        add_word(encode_dp(COND_GT, 1, OP_MOV, 0, 0, 12, 12'h00d));
        add_word(encode_dp(COND_LE, 1, OP_MOV, 0, 0, 12, 12'h00e));
        add_row(32'hea00_0004, 32'h0000_0100, 1'b0);                  // b, taken.
        add_word(encode_dp(COND_AL, 1, OP_MOV, 0, 0, 1, 12'h055));   // squashed.
        add_word(encode_dp(COND_AL, 1, OP_CMP, 1, 1, 14, 12'h0ff));
        add_row(32'h1a00_0010, 32'h0000_0200, 1'b0);                  // bne, not taken.
        add_word(encode_dp(COND_AL, 1, OP_MOV, 0, 0, 2, 12'h012));
        repeat (4) add_row(32'h0, 32'h0, 1'b1);
        add_word(encode_dp(COND_AL, 1, OP_ADD, 0, 2, 3, 12'h001));
    endtask

    initial begin
        hold        = 1'b0;
        drain_done  = 1'b0;
        load_program();
        instr_valid = 1'b1;                // first word waits out the reset.
        instr       = row_word[0];
        pc          = row_pc[0];
        @(negedge rst);
        foreach (row_word[i]) begin
            instr_valid <= !row_hold[i];
            instr       <= row_word[i];
            pc          <= row_pc[i];
            hold        <= row_hold[i];
            if (row_hold[i]) begin
                @(posedge clk);
            end else begin
                do @(posedge clk); while (!instr_ready);   // consumed at this edge.
            end
        end
        instr_valid <= 1'b0;
        hold        <= 1'b0;
        repeat (6) @(posedge clk);
        drain_done <= 1'b1;
        repeat (2) @(posedge clk);
        $display("errors: value %0d, count %0d", value_errors, count_errors);
        if ((value_errors + count_errors) == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #1;
        #((row_word.size() + 20) * 40 * 4);
        $display("timeout: the stimulus loop did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: testbench/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;    // 40 ns period.
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule
